//--- include/armExec_config.svh
`ifndef ARM_EXEC_CONFIG_SVH
`define ARM_EXEC_CONFIG_SVH

// Datapath sizing
`define ARM_DATA_W 32  // Register and operand width
`define ARM_REG_W 4    // Register index width

// Testbench sizing
`define ARM_TB_NUM_CMDS 2000        // Random commands per run
`define ARM_TB_CLK_PERIOD 8         // Clock period in ns
`define ARM_TB_RESET_CYCLES 2       // Reset held this many cycles
`define ARM_TB_SEED 32'h02fa_1a63   // $random seed
`define ARM_TB_LATENCY 2            // Command to result cycles

`endif

//--- verilog/armExecPkg.sv
`include "armExec_config.svh"

package armExecPkg;

  typedef enum logic [1:0] {
    shNone     = 2'd0,  // Rm passes straight through
    shRType    = 2'd1,  // Immediate amount in shiftSrc[11:7]
    shRsrType  = 2'd2,  // Amount from low byte of Rs
    shMemShift = 2'd3   // Load/store address offset shift
  } shiftKind_e;

  // Data-processing opcodes in instruction encoding order
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } aluOp_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    aluOp_e                  aluOp;
    shiftKind_e              shiftKind;
    logic [1:0]              shiftOp;     // RSR shift type
    logic                    zeroRotate;
    logic                    setFlags;
    logic [`ARM_REG_W-1:0]   destReg;
    logic [`ARM_DATA_W-1:0]  rn;
    logic [`ARM_DATA_W-1:0]  shiftSrc;    // Immediate bits or Rs value
    logic [`ARM_DATA_W-1:0]  rm;
  } exCmd_t;

  typedef struct packed {
    logic [`ARM_DATA_W-1:0]  result;
    logic [`ARM_REG_W-1:0]   destReg;
    logic                    writeEn;
    flags_t                  flags;
  } exResult_t;

endpackage

//--- verilog/shifter.sv
`timescale 1ns/1ps
`include "armExec_config.svh"

module shifter (
  input  logic [`ARM_DATA_W-1:0]  shiftSrc,
  input  logic [`ARM_DATA_W-1:0]  rm,
  input  armExecPkg::shiftKind_e  shiftKind,
  input  logic [1:0]              shiftOp,
  input  logic                    zeroRotate,
  input  logic                    prevC,
  output logic [`ARM_DATA_W-1:0]  shiftOut,
  output logic                    shiftCarry
);

  localparam int Msb = `ARM_DATA_W - 1;

  logic [4:0]               immAmt;   // R-type and memory shift amount
  logic [1:0]               immType;
  logic [7:0]               regAmt;   // Low byte of Rs
  logic [`ARM_DATA_W-1:0]   signFill;
  logic [`ARM_DATA_W-1:0]   rrxVal;

  // Left shifts carry an extra MSB and right shifts an extra LSB
  // so the last bit shifted out lands in a fixed position
  logic [`ARM_DATA_W:0]     lslImm;
  logic [`ARM_DATA_W:0]     lsrImm;
  logic [`ARM_DATA_W:0]     asrImm;
  logic [2*`ARM_DATA_W-1:0] rorImm;
  logic [`ARM_DATA_W:0]     lslReg;
  logic [`ARM_DATA_W:0]     lsrReg;
  logic [`ARM_DATA_W:0]     asrReg;
  logic [2*`ARM_DATA_W-1:0] rorReg;

  assign immAmt   = shiftSrc[11:7];
  assign immType  = shiftSrc[6:5];
  assign regAmt   = shiftSrc[7:0];
  assign signFill = {`ARM_DATA_W{rm[Msb]}};
  assign rrxVal   = {prevC, rm[Msb:1]};  // Old carry rotates in at the top

  assign lslImm = {1'b0, rm} << immAmt;
  assign lsrImm = {rm, 1'b0} >> immAmt;  // Zero fill, no multiply carry
  assign asrImm = $signed({rm, 1'b0}) >>> immAmt;
  assign rorImm = {rm, rm} >> immAmt;

  assign lslReg = {1'b0, rm} << regAmt[4:0];  // Only used below 32
  assign lsrReg = {rm, 1'b0} >> regAmt[4:0];
  assign asrReg = $signed({rm, 1'b0}) >>> regAmt[4:0];
  assign rorReg = {rm, rm} >> regAmt[4:0];

  always_comb begin
    shiftOut   = rm;
    shiftCarry = rm[Msb];
    case (shiftKind)
      armExecPkg::shRType: begin
        case (immType)
          2'b00: begin  // LSL, zero amount keeps old carry
            shiftOut   = lslImm[Msb:0];
            shiftCarry = (immAmt == 5'd0) ? prevC : lslImm[`ARM_DATA_W];
          end
          2'b01: begin  // LSR, zero amount means 32
            if (immAmt == 5'd0) begin
              shiftOut   = '0;
              shiftCarry = rm[Msb];
            end else begin
              shiftOut   = lsrImm[`ARM_DATA_W:1];
              shiftCarry = lsrImm[0];
            end
          end
          2'b10: begin  // ASR, zero amount means 32
            if (immAmt == 5'd0) begin
              shiftOut   = signFill;
              shiftCarry = rm[Msb];
            end else begin
              shiftOut   = asrImm[`ARM_DATA_W:1];
              shiftCarry = asrImm[0];
            end
          end
          default: begin
            if (immAmt == 5'd0) begin  // RRX
              shiftOut   = rrxVal;
              shiftCarry = rm[0];
            end else begin  // ROR
              shiftOut   = rorImm[Msb:0];
              shiftCarry = rorImm[Msb];
            end
          end
        endcase
      end

      armExecPkg::shRsrType: begin
        if (regAmt == 8'd0) begin  // No shift for any type
          shiftOut   = rm;
          shiftCarry = prevC;
        end else begin
          case (shiftOp)
            2'b00: begin  // LSL
              if (regAmt < `ARM_DATA_W) begin
                shiftOut   = lslReg[Msb:0];
                shiftCarry = lslReg[`ARM_DATA_W];
              end else begin
                shiftOut   = '0;
                shiftCarry = (regAmt == `ARM_DATA_W) ? rm[0] : 1'b0;
              end
            end
            2'b01: begin  // LSR
              if (regAmt < `ARM_DATA_W) begin
                shiftOut   = lsrReg[`ARM_DATA_W:1];
                shiftCarry = lsrReg[0];
              end else begin
                shiftOut   = '0;
                shiftCarry = (regAmt == `ARM_DATA_W) ? rm[Msb] : 1'b0;
              end
            end
            2'b10: begin  // ASR saturates to sign
              if (regAmt < `ARM_DATA_W) begin
                shiftOut   = asrReg[`ARM_DATA_W:1];
                shiftCarry = asrReg[0];
              end else begin
                shiftOut   = signFill;
                shiftCarry = rm[Msb];
              end
            end
            default: begin
              // ROR by a multiple of 32 leaves Rm in place
              if (regAmt[4:0] == 5'd0) begin
                shiftOut   = rm;
                shiftCarry = rm[Msb];
              end else begin
                shiftOut   = rorReg[Msb:0];
                shiftCarry = rorReg[Msb];
              end
            end
          endcase
        end
      end

      armExecPkg::shMemShift: begin
        shiftCarry = 1'b0;  // Address shifts never produce a carry
        case (immType)
          2'b00:   shiftOut = lslImm[Msb:0];
          2'b01:   shiftOut = lsrImm[`ARM_DATA_W:1];
          2'b10:   shiftOut = asrImm[`ARM_DATA_W:1];
          default: shiftOut = (immAmt == 5'd0) ? rrxVal : rorImm[Msb:0];
        endcase
      end

      default: begin  // Pass-through
        shiftOut   = rm;
        shiftCarry = zeroRotate ? prevC : rm[Msb];
      end
    endcase
  end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/1ps
`include "armExec_config.svh"

module aluUnit (
  input  armExecPkg::aluOp_e      aluOp,
  input  logic [`ARM_DATA_W-1:0]  rn,
  input  logic [`ARM_DATA_W-1:0]  shifted,
  input  logic                    shiftCarry,
  input  logic                    setFlags,
  input  logic [`ARM_REG_W-1:0]   destReg,
  input  armExecPkg::flags_t      curFlags,
  output armExecPkg::exResult_t   aluResult
);

  localparam int Msb = `ARM_DATA_W - 1;

  logic [`ARM_DATA_W-1:0] addA;
  logic [`ARM_DATA_W-1:0] addB;
  logic                   addCin;
  logic [`ARM_DATA_W:0]   sum;      // Bit 32 is the adder carry
  logic                   overflow;
  logic                   isArith;
  logic                   isTest;
  logic [`ARM_DATA_W-1:0] logicVal;
  logic [`ARM_DATA_W-1:0] value;
  armExecPkg::flags_t     calcFlags;

  // Subtraction is A + ~B + 1, with the old carry as the borrow-in
  always_comb begin
    addA     = rn;
    addB     = shifted;
    addCin   = 1'b0;
    isArith  = 1'b1;
    logicVal = '0;
    case (aluOp)
      armExecPkg::opAnd, armExecPkg::opTst: begin
        isArith  = 1'b0;
        logicVal = rn & shifted;
      end
      armExecPkg::opEor, armExecPkg::opTeq: begin
        isArith  = 1'b0;
        logicVal = rn ^ shifted;
      end
      armExecPkg::opSub, armExecPkg::opCmp: begin
        addB   = ~shifted;
        addCin = 1'b1;
      end
      armExecPkg::opRsb: begin
        addA   = shifted;
        addB   = ~rn;
        addCin = 1'b1;
      end
      armExecPkg::opAdc: addCin = curFlags.c;
      armExecPkg::opSbc: begin
        addB   = ~shifted;
        addCin = curFlags.c;
      end
      armExecPkg::opRsc: begin
        addA   = shifted;
        addB   = ~rn;
        addCin = curFlags.c;
      end
      armExecPkg::opOrr: begin
        isArith  = 1'b0;
        logicVal = rn | shifted;
      end
      armExecPkg::opMov: begin
        isArith  = 1'b0;
        logicVal = shifted;
      end
      armExecPkg::opBic: begin
        isArith  = 1'b0;
        logicVal = rn & ~shifted;
      end
      armExecPkg::opMvn: begin
        isArith  = 1'b0;
        logicVal = ~shifted;
      end
      default: ;  // ADD and CMN use the defaults
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {{`ARM_DATA_W{1'b0}}, addCin};
  assign overflow = (addA[Msb] == addB[Msb]) && (sum[Msb] != addA[Msb]);
  assign value    = isArith ? sum[Msb:0] : logicVal;

  assign isTest = (aluOp == armExecPkg::opTst) || (aluOp == armExecPkg::opTeq) ||
                  (aluOp == armExecPkg::opCmp) || (aluOp == armExecPkg::opCmn);

  assign calcFlags.n = value[Msb];
  assign calcFlags.z = (value == '0);
  assign calcFlags.c = isArith ? sum[`ARM_DATA_W] : shiftCarry;
  assign calcFlags.v = isArith ? overflow : curFlags.v;  // Logical ops keep V

  assign aluResult.result  = value;
  assign aluResult.destReg = destReg;
  assign aluResult.writeEn = ~isTest;
  assign aluResult.flags   = setFlags ? calcFlags : curFlags;

endmodule

//--- verilog/flagUnit.sv
`timescale 1ns/1ps

module flagUnit (
  input  logic                clk,
  input  logic                isLDRSTR_shift,
  input  logic                update,
  input  armExecPkg::flags_t  newFlags,
  output armExecPkg::flags_t  flags,
  output logic                prevC
);

  // NZCV state, visible to the next command one edge after an update
  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      flags <= '0;
    end else if (update) begin
      flags <= newFlags;  // ALU already folded in setFlags
    end
  end

  assign prevC = flags.c;  // Carry for shifter and ADC/SBC/RSC

endmodule

//--- verilog/pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
  parameter type payload_t = logic
) (
  input  logic      clk,
  input  logic      isLDRSTR_shift,
  input  logic      inValid,
  input  payload_t  inData,
  output logic      outValid,
  output payload_t  outData
);

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      outData <= inData;  // Holds last payload while idle
    end
  end

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`include "armExec_config.svh"

module executeStage (
  input  logic                   clk,
  input  logic                   isLDRSTR_shift,
  input  logic                   cmdValid,
  input  armExecPkg::exCmd_t     cmd,
  output logic                   resValid,
  output armExecPkg::exResult_t  res
);

  logic                   exValid;
  armExecPkg::exCmd_t     exCmd;
  logic [`ARM_DATA_W-1:0] shiftOut;
  logic                   shiftCarry;
  armExecPkg::exResult_t  aluResult;
  armExecPkg::flags_t     flags;
  logic                   prevC;

  pipeStage #(.payload_t(armExecPkg::exCmd_t)) i_cmdStage (
    .clk           (clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .inValid       (cmdValid),
    .inData        (cmd),
    .outValid      (exValid),
    .outData       (exCmd)
  );

  shifter i_shifter (
    .shiftSrc  (exCmd.shiftSrc),
    .rm        (exCmd.rm),
    .shiftKind (exCmd.shiftKind),
    .shiftOp   (exCmd.shiftOp),
    .zeroRotate(exCmd.zeroRotate),
    .prevC     (prevC),
    .shiftOut  (shiftOut),
    .shiftCarry(shiftCarry)
  );

  aluUnit i_alu (
    .aluOp     (exCmd.aluOp),
    .rn        (exCmd.rn),
    .shifted   (shiftOut),
    .shiftCarry(shiftCarry),
    .setFlags  (exCmd.setFlags),
    .destReg   (exCmd.destReg),
    .curFlags  (flags),
    .aluResult (aluResult)
  );

  flagUnit i_flags (
    .clk           (clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .update        (exValid),  // Same edge as the result register
    .newFlags      (aluResult.flags),
    .flags         (flags),
    .prevC         (prevC)
  );

  pipeStage #(.payload_t(armExecPkg::exResult_t)) i_resStage (
    .clk           (clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .inValid       (exValid),
    .inData        (aluResult),
    .outValid      (resValid),
    .outData       (res)
  );

endmodule

//--- verif/executeStage_asserts.sv
`timescale 1ns/1ps

module executeStage_asserts (
  input logic                   clk,
  input logic                   isLDRSTR_shift,
  input logic                   cmdValid,
  input logic                   exValid,
  input armExecPkg::exCmd_t     exCmd,
  input logic                   resValid,
  input armExecPkg::exResult_t  res
);

  int failCount;  // Read by the testbench report

  resetClears: assert property (@(posedge clk) isLDRSTR_shift |=> !resValid)
    else begin
      failCount++;
      $error("resValid high in the cycle after reset");
    end

  // Every strobe comes out exactly two edges later, and nothing else does
  fixedLatency: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    resValid == $past(cmdValid, 2))
    else begin
      failCount++;
      $error("resValid does not follow cmdValid two cycles later");
    end

  testNoWrite: assert property (@(posedge clk) disable iff (isLDRSTR_shift)
    exValid && (exCmd.aluOp inside {armExecPkg::opTst, armExecPkg::opTeq,
                                    armExecPkg::opCmp, armExecPkg::opCmn})
    |=> !res.writeEn)
    else begin
      failCount++;
      $error("writeEn high for a test opcode");
    end

endmodule

bind executeStage executeStage_asserts i_asserts (.*);

//--- verif/executeChecker.sv
`timescale 1ns/1ps
`include "armExec_config.svh"

module executeChecker (
  input  logic                   clk,
  input  logic                   isLDRSTR_shift,
  input  logic                   cmdValid,
  input  armExecPkg::exCmd_t     cmd,
  input  logic                   resValid,
  input  armExecPkg::exResult_t  res,
  output int                     valueErrs,
  output int                     timingErrs,
  output int                     acceptCount,
  output int                     resultCount
);

  localparam int W = `ARM_DATA_W;
  localparam int Lat = `ARM_TB_LATENCY;

  armExecPkg::flags_t     modelFlags;
  armExecPkg::exResult_t  expQ[$];
  armExecPkg::exResult_t  expNext;
  armExecPkg::exResult_t  want;
  logic [Lat-1:0]         validHist = '0;  // Accept history, oldest on top

  // Shift by 1 to 31, result in the low bits and last bit out on top
  function automatic logic [W:0] shiftInRange(logic [1:0] typ, int n, logic [W-1:0] v);
    logic [W-1:0] out;
    case (typ)
      2'b00:   out = v << n;
      2'b01:   out = v >> n;
      2'b10:   out = $signed(v) >>> n;
      default: out = (v >> n) | (v << (W - n));
    endcase
    return {(typ == 2'b00) ? v[W - n] : v[n - 1], out};
  endfunction

  function automatic logic [W:0] shiftModel(armExecPkg::exCmd_t k, logic c);
    logic [4:0]   imm;
    logic [1:0]   typ;
    logic [7:0]   amt;
    logic [W-1:0] v;
    logic [W:0]   r;
    v   = k.rm;
    imm = k.shiftSrc[11:7];
    typ = k.shiftSrc[6:5];
    amt = k.shiftSrc[7:0];
    case (k.shiftKind)
      armExecPkg::shRType: begin
        if (imm != 5'd0) return shiftInRange(typ, imm, v);
        case (typ)
          2'b00:   return {c, v};
          2'b11:   return {v[0], c, v[W-1:1]};  // RRX
          default: return {v[W-1], (typ == 2'b10) ? {W{v[W-1]}} : {W{1'b0}}};
        endcase
      end
      armExecPkg::shRsrType: begin
        if (amt == 8'd0) return {c, v};
        if (amt < W) return shiftInRange(k.shiftOp, amt, v);
        case (k.shiftOp)
          2'b00:   return {(amt == W) ? v[0] : 1'b0, {W{1'b0}}};
          2'b01:   return {(amt == W) ? v[W-1] : 1'b0, {W{1'b0}}};
          2'b10:   return {v[W-1], {W{v[W-1]}}};
          default: return (amt[4:0] == 5'd0) ? {v[W-1], v} : shiftInRange(2'b11, amt[4:0], v);
        endcase
      end
      armExecPkg::shMemShift: begin
        if (imm == 5'd0) begin
          r = (typ == 2'b11) ? {1'b0, c, v[W-1:1]} : {1'b0, v};
        end else begin
          r = shiftInRange(typ, imm, v);
        end
        return {1'b0, r[W-1:0]};  // Never a carry
      end
      default: return {k.zeroRotate ? c : v[W-1], v};
    endcase
  endfunction

  function automatic armExecPkg::exResult_t aluModel(armExecPkg::exCmd_t k, logic [W:0] sh,
                                                     armExecPkg::flags_t f);
    logic [W-1:0]          b;
    logic [W-1:0]          p;
    logic [W-1:0]          q;
    logic [W-1:0]          val;
    logic                  arith;
    logic                  sub;
    longint                ci;
    longint                u;
    longint                s;
    armExecPkg::flags_t    nf;
    armExecPkg::exResult_t r;
    b     = sh[W-1:0];
    nf    = f;
    nf.c  = sh[W];  // Logical ops take the shifter carry
    arith = 1'b1;
    sub   = 1'b1;
    p     = k.rn;
    q     = b;
    ci    = 1;
    val   = '0;
    case (k.aluOp)
      armExecPkg::opAnd, armExecPkg::opTst: val = k.rn & b;
      armExecPkg::opEor, armExecPkg::opTeq: val = k.rn ^ b;
      armExecPkg::opOrr: val = k.rn | b;
      armExecPkg::opMov: val = b;
      armExecPkg::opBic: val = k.rn & ~b;
      armExecPkg::opMvn: val = ~b;
      default: ;
    endcase
    case (k.aluOp)
      armExecPkg::opAdd, armExecPkg::opCmn: begin
        sub = 1'b0;
        ci  = 0;
      end
      armExecPkg::opAdc: begin
        sub = 1'b0;
        ci  = f.c;
      end
      armExecPkg::opSub, armExecPkg::opCmp: ;
      armExecPkg::opRsb: begin
        p = b;
        q = k.rn;
      end
      armExecPkg::opSbc: ci = f.c;
      armExecPkg::opRsc: begin
        p  = b;
        q  = k.rn;
        ci = f.c;
      end
      default: arith = 1'b0;
    endcase
    if (arith) begin
      if (sub) begin  // Carry means no borrow
        u    = longint'(p) - longint'(q) - (1 - ci);
        s    = longint'($signed(p)) - longint'($signed(q)) - (1 - ci);
        nf.c = (u >= 0);
      end else begin
        u    = longint'(p) + longint'(q) + ci;
        s    = longint'($signed(p)) + longint'($signed(q)) + ci;
        nf.c = (u >= (longint'(1) << W));
      end
      nf.v = (s < -(longint'(1) << (W - 1))) || (s >= (longint'(1) << (W - 1)));
      val  = u[W-1:0];
    end
    nf.n      = val[W-1];
    nf.z      = (val == '0);
    r.result  = val;
    r.destReg = k.destReg;
    r.writeEn = !(k.aluOp inside {armExecPkg::opTst, armExecPkg::opTeq,
                                  armExecPkg::opCmp, armExecPkg::opCmn});
    r.flags   = k.setFlags ? nf : f;
    return r;
  endfunction

  task automatic checkField(string name, logic [W-1:0] got, logic [W-1:0] exp);
    if (got !== exp) begin
      valueErrs++;
      $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Model runs commands in order, so each sees the flags of the one before
  always @(posedge clk) begin
    if (isLDRSTR_shift) begin
      modelFlags = '0;
      validHist  = '0;
      expQ.delete();
    end else begin
      validHist = {validHist[Lat-2:0], cmdValid};
      if (cmdValid) begin
        expNext    = aluModel(cmd, shiftModel(cmd, modelFlags.c), modelFlags);
        modelFlags = expNext.flags;
        expQ.push_back(expNext);
        acceptCount++;
      end
    end
  end

  // Outputs settled mid-cycle, one edge after the result register loads
  always @(negedge clk) begin
    if (!isLDRSTR_shift) begin
      if (resValid !== validHist[Lat-1]) begin
        timingErrs++;
        $display("ERR %0t: resValid is %b, expected %b", $time, resValid, validHist[Lat-1]);
      end
      if (resValid === 1'b1) resultCount++;
      if (validHist[Lat-1] && expQ.size() > 0) begin
        want = expQ.pop_front();
        if (resValid === 1'b1) begin
          checkField("result", res.result, want.result);
          checkField("destReg", res.destReg, want.destReg);
          checkField("writeEn", res.writeEn, want.writeEn);
          checkField("flags", res.flags, want.flags);
        end
      end
    end
  end

endmodule

//--- verif/executeStage_tb.sv
`timescale 1ns/1ps
`include "armExec_config.svh"

module executeStage_tb;

  logic                   clk;
  logic                   isLDRSTR_shift;
  logic                   cmdValid;
  armExecPkg::exCmd_t     cmd;
  logic                   resValid;
  armExecPkg::exResult_t  res;
  integer                 seed;
  logic [31:0]            pick;
  int                     valueErrs;
  int                     timingErrs;
  int                     acceptCount;
  int                     resultCount;
  int                     countErrs;
  int                     totalErrs;

  executeStage i_dut (
    .clk           (clk),
    .isLDRSTR_shift(isLDRSTR_shift),
    .cmdValid      (cmdValid),
    .cmd           (cmd),
    .resValid      (resValid),
    .res           (res)
  );

  executeChecker i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #(`ARM_TB_CLK_PERIOD / 2) clk = ~clk;
  end

  // Amounts near the shifter edge cases come up often
  function automatic logic [7:0] pickAmount();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return 8'd0;
      3'd1:    return 8'd1;
      3'd2:    return 8'd31;
      3'd3:    return 8'd32;
      3'd4:    return (r[15:8] > 8'd32) ? r[15:8] : 8'd33 + r[12:8];
      3'd5:    return r[15:8];
      default: return {3'b000, r[12:8]};
    endcase
  endfunction

  function automatic logic [31:0] pickData();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7fff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  function automatic armExecPkg::exCmd_t randomCmd();
    armExecPkg::exCmd_t k;
    logic [31:0]        r;
    logic [7:0]         amt;
    r            = $random(seed);
    k.aluOp      = (r[16:15] == 2'b00) ? armExecPkg::opMov : armExecPkg::aluOp_e'(r[3:0]);
    k.shiftKind  = armExecPkg::shiftKind_e'(r[5:4]);
    k.shiftOp    = r[7:6];
    k.zeroRotate = r[8];
    k.setFlags   = (r[10:9] != 2'b00);
    k.destReg    = r[14:11];
    k.rn         = pickData();
    k.rm         = pickData();
    k.shiftSrc   = $random(seed);
    amt          = pickAmount();
    if (k.shiftKind == armExecPkg::shRsrType) k.shiftSrc[7:0] = amt;
    else k.shiftSrc[11:7] = amt[4:0];
    return k;
  endfunction

  initial begin
    seed           = `ARM_TB_SEED;
    isLDRSTR_shift = 1'b1;
    cmdValid       = 1'b0;
    cmd            = '0;
    countErrs      = 0;
    repeat (`ARM_TB_RESET_CYCLES) @(posedge clk);
    #1;
    isLDRSTR_shift = 1'b0;
    repeat (`ARM_TB_NUM_CMDS) begin
      pick     = $random(seed);
      cmdValid = (pick[1:0] != 2'b00);  // About 75% busy
      cmd      = randomCmd();
      @(posedge clk);
      #1;
    end
    cmdValid = 1'b0;
    @(posedge clk);
    wait (resultCount == acceptCount);
    repeat (4) @(posedge clk);  // Catch stray results
    if (resultCount != acceptCount) begin
      countErrs++;
      $display("Result count %0d does not match %0d accepted commands",
               resultCount, acceptCount);
    end
    totalErrs = valueErrs + timingErrs + countErrs + i_dut.i_asserts.failCount;
    $display("Errors: value %0d, timing %0d, count %0d, assertion %0d over %0d commands",
             valueErrs, timingErrs, countErrs, i_dut.i_asserts.failCount, acceptCount);
    if (totalErrs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #((`ARM_TB_NUM_CMDS + 20) * `ARM_TB_CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("tests failed");
    $finish;
  end

endmodule

//--- armExec.f
+incdir+include
verilog/armExecPkg.sv
verilog/shifter.sv
verilog/aluUnit.sv
verilog/flagUnit.sv
verilog/pipeStage.sv
verilog/executeStage.sv
verif/executeStage_asserts.sv
verif/executeChecker.sv
verif/executeStage_tb.sv
